//--- gbc_io_top.f
+incdir+logic
logic/gbc_io_pkg.sv
logic/io_bus_decoder.sv
logic/timer_control.sv
logic/timer_counter.sv
logic/interrupt_controller.sv
logic/io_scratch_regs.sv
logic/gbc_io_top.sv
test/gbc_io_checker.sv
test/gbc_io_tb.sv

//--- logic/gbc_io_defs.svh
`ifndef GBC_IO_DEFS_SVH
`define GBC_IO_DEFS_SVH

// Timer registers
`define DIV_ADDR        16'hFF04
`define TIMA_ADDR       16'hFF05
`define TMA_ADDR        16'hFF06
`define TAC_ADDR        16'hFF07

// Interrupt registers
`define IF_ADDR         16'hFF0F
`define IE_ADDR         16'hFFFF

// Infrared port and undocumented registers
`define RP_ADDR         16'hFF56
`define UNUSED_6C_ADDR  16'hFF6C
`define UNUSED_72_ADDR  16'hFF72
`define UNUSED_73_ADDR  16'hFF73
`define UNUSED_74_ADDR  16'hFF74
`define UNUSED_75_ADDR  16'hFF75
`define UNUSED_76_ADDR  16'hFF76
`define UNUSED_77_ADDR  16'hFF77

// Reset values and writable bits
`define RP_RESET        8'hFD
`define UNUSED_6C_RESET 8'hFE
`define UNUSED_75_RESET 8'h8F
`define RP_WMASK        8'hC1
`define UNUSED_6C_WMASK 8'h01
`define UNUSED_75_WMASK 8'h70

// Read padding
`define OPEN_BUS_DATA   8'hFF
`define IF_UNUSED_BITS  8'hE0
`define TAC_UNUSED_BITS 8'hF8

// Periods in clock cycles, indexed by TAC[1:0]
`define TIMER_PERIOD_0  1024
`define TIMER_PERIOD_1  16
`define TIMER_PERIOD_2  64
`define TIMER_PERIOD_3  256
`define DIV_PERIOD      256

`endif

//--- logic/gbc_io_pkg.sv
package gbc_io_pkg;

   // ==================================================
   // Bus types
   // ==================================================
   typedef logic [15:0] io_addr_t;
   typedef logic [7:0]  io_data_t;

   // Which register block an address lands in
   typedef enum logic [1:0] {
      BLK_NONE,
      BLK_TIMER,
      BLK_INT,
      BLK_SCRATCH
   } io_block_t;

   // Decoder handshake states
   typedef enum logic {
      BUS_IDLE,
      BUS_RESPONDING
   } bus_state_t;

   // ==================================================
   // Interrupt types
   // ==================================================
   // 0 vblank, 1 lcdstat, 2 timer, 3 serial, 4 joypad
   typedef logic [4:0] int_vec_t;
   typedef logic [2:0] int_index_t;

endpackage

//--- logic/gbc_io_top.sv
module gbc_io_top import gbc_io_pkg::*; (
   input  logic       clock,
   input  logic       rst,
   // Host request channel
   input  logic       req_valid,
   input  logic       req_write,
   input  io_addr_t   req_addr,
   input  io_data_t   req_wdata,
   output logic       req_ready,
   // Host response channel
   output logic       resp_valid,
   input  logic       resp_ready,
   output io_data_t   resp_rdata,
   // Requests from blocks outside this design
   input  logic       vblank_req,
   input  logic       lcdstat_req,
   input  logic       serial_req,
   input  logic       joypad_req,
   // Processor interrupt side
   input  logic       int_ack,
   output logic       irq,
   output int_index_t irq_index
);

   // ==================================================
   // Internal register bus
   // ==================================================
   logic       timer_sel;
   logic       int_sel;
   logic       scratch_sel;
   logic       wr_en;
   io_addr_t   reg_addr;
   io_data_t   wdata;
   io_data_t   timer_rdata;
   io_data_t   int_rdata;
   io_data_t   scratch_rdata;

   // Timer internals
   io_data_t   tma;
   io_data_t   tac_rdata;
   logic       timer_enable;
   logic [1:0] tick_period_sel;
   logic       timer_irq_pulse;

   // ==================================================
   // Blocks
   // ==================================================
   io_bus_decoder u_decoder (
      .clock         (clock),
      .rst           (rst),
      .req_valid     (req_valid),
      .req_write     (req_write),
      .req_addr      (req_addr),
      .req_wdata     (req_wdata),
      .req_ready     (req_ready),
      .resp_valid    (resp_valid),
      .resp_ready    (resp_ready),
      .resp_rdata    (resp_rdata),
      .timer_sel     (timer_sel),
      .int_sel       (int_sel),
      .scratch_sel   (scratch_sel),
      .wr_en         (wr_en),
      .reg_addr      (reg_addr),
      .wdata         (wdata),
      .timer_rdata   (timer_rdata),
      .int_rdata     (int_rdata),
      .scratch_rdata (scratch_rdata)
   );

   timer_control u_timer_ctrl (
      .clock           (clock),
      .rst             (rst),
      .timer_sel       (timer_sel),
      .wr_en           (wr_en),
      .reg_addr        (reg_addr),
      .wdata           (wdata),
      .tma             (tma),
      .tac_rdata       (tac_rdata),
      .timer_enable    (timer_enable),
      .tick_period_sel (tick_period_sel)
   );

   timer_counter u_timer_cnt (
      .clock           (clock),
      .rst             (rst),
      .timer_sel       (timer_sel),
      .wr_en           (wr_en),
      .reg_addr        (reg_addr),
      .wdata           (wdata),
      .tma             (tma),
      .tac_rdata       (tac_rdata),
      .timer_enable    (timer_enable),
      .tick_period_sel (tick_period_sel),
      .timer_rdata     (timer_rdata),
      .timer_irq_pulse (timer_irq_pulse)
   );

   interrupt_controller u_int_ctrl (
      .clock           (clock),
      .rst             (rst),
      .int_sel         (int_sel),
      .wr_en           (wr_en),
      .reg_addr        (reg_addr),
      .wdata           (wdata),
      .vblank_req      (vblank_req),
      .lcdstat_req     (lcdstat_req),
      .timer_irq_pulse (timer_irq_pulse),
      .serial_req      (serial_req),
      .joypad_req      (joypad_req),
      .int_ack         (int_ack),
      .irq             (irq),
      .irq_index       (irq_index),
      .int_rdata       (int_rdata)
   );

   io_scratch_regs u_scratch (
      .clock         (clock),
      .rst           (rst),
      .scratch_sel   (scratch_sel),
      .wr_en         (wr_en),
      .reg_addr      (reg_addr),
      .wdata         (wdata),
      .scratch_rdata (scratch_rdata)
   );

endmodule

//--- logic/interrupt_controller.sv
`include "gbc_io_defs.svh"

module interrupt_controller import gbc_io_pkg::*; (
   input  logic       clock,
   input  logic       rst,
   input  logic       int_sel,
   input  logic       wr_en,
   input  io_addr_t   reg_addr,
   input  io_data_t   wdata,
   input  logic       vblank_req,
   input  logic       lcdstat_req,
   input  logic       timer_irq_pulse,
   input  logic       serial_req,
   input  logic       joypad_req,
   input  logic       int_ack,
   output logic       irq,
   output int_index_t irq_index,
   output io_data_t   int_rdata
);

   int_vec_t if_reg;
   int_vec_t if_next;
   io_data_t ie_reg;
   int_vec_t req_vec;
   int_vec_t pending;
   logic     write_if;
   logic     write_ie;

   assign req_vec  = {joypad_req, serial_req, timer_irq_pulse, lcdstat_req, vblank_req};
   assign write_if = int_sel && wr_en && (reg_addr == `IF_ADDR);
   assign write_ie = int_sel && wr_en && (reg_addr == `IE_ADDR);

   // ==================================================
   // Flag update
   // ==================================================
   // Host write first, then acknowledge, then new requests on top
   always_comb begin
      if_next = if_reg;
      if (write_if) begin
         if_next = wdata[4:0];
      end
      if (irq && int_ack) begin
         if_next[irq_index] = 1'b0;
      end
      if_next = if_next | req_vec;
   end

   always_ff @(posedge clock) begin
      if (rst) begin
         if_reg <= '0;
         ie_reg <= '0;
      end else begin
         if_reg <= if_next;
         if (write_ie) begin
            ie_reg <= wdata;
         end
      end
   end

   // ==================================================
   // Priority
   // ==================================================
   assign pending = if_reg & ie_reg[4:0];
   assign irq     = |pending;

   // Scan downward so vblank ends up winning
   always_comb begin
      irq_index = '0;
      for (int i = 4; i >= 0; i--) begin
         if (pending[i]) begin
            irq_index = int_index_t'(i);
         end
      end
   end

   always_comb begin
      case (reg_addr)
         `IF_ADDR: int_rdata = `IF_UNUSED_BITS | {3'b000, if_reg};
         `IE_ADDR: int_rdata = ie_reg;
         default:  int_rdata = `OPEN_BUS_DATA;
      endcase
   end

endmodule

//--- logic/io_bus_decoder.sv
`include "gbc_io_defs.svh"

module io_bus_decoder import gbc_io_pkg::*; (
   input  logic     clock,
   input  logic     rst,
   input  logic     req_valid,
   input  logic     req_write,
   input  io_addr_t req_addr,
   input  io_data_t req_wdata,
   output logic     req_ready,
   output logic     resp_valid,
   input  logic     resp_ready,
   output io_data_t resp_rdata,
   output logic     timer_sel,
   output logic     int_sel,
   output logic     scratch_sel,
   output logic     wr_en,
   output io_addr_t reg_addr,
   output io_data_t wdata,
   input  io_data_t timer_rdata,
   input  io_data_t int_rdata,
   input  io_data_t scratch_rdata
);

   bus_state_t state;
   bus_state_t state_next;
   io_block_t  req_block;
   io_data_t   read_mux;
   logic       accept;

   // Map an address to the block that owns it
   function automatic io_block_t classify(input io_addr_t addr);
      case (addr)
         `DIV_ADDR, `TIMA_ADDR, `TMA_ADDR, `TAC_ADDR:
            return BLK_TIMER;
         `IF_ADDR, `IE_ADDR:
            return BLK_INT;
         `RP_ADDR, `UNUSED_6C_ADDR, `UNUSED_72_ADDR, `UNUSED_73_ADDR,
         `UNUSED_74_ADDR, `UNUSED_75_ADDR, `UNUSED_76_ADDR, `UNUSED_77_ADDR:
            return BLK_SCRATCH;
         default:
            return BLK_NONE;
      endcase
   endfunction

   // ==================================================
   // Handshake
   // ==================================================
   // No new request while a read response is outstanding
   assign req_ready  = (state == BUS_IDLE);
   assign resp_valid = (state == BUS_RESPONDING);
   assign accept     = req_valid && req_ready;

   always_comb begin
      state_next = state;
      case (state)
         BUS_IDLE: begin
            if (accept && !req_write) begin
               state_next = BUS_RESPONDING;
            end
         end
         BUS_RESPONDING: begin
            if (resp_ready) begin
               state_next = BUS_IDLE;
            end
         end
         default: state_next = BUS_IDLE;
      endcase
   end

   always_ff @(posedge clock) begin
      if (rst) begin
         state <= BUS_IDLE;
      end else begin
         state <= state_next;
      end
   end

   // ==================================================
   // Decode and read data
   // ==================================================
   assign req_block   = classify(req_addr);
   assign reg_addr    = req_addr;
   assign wdata       = req_wdata;
   assign wr_en       = accept && req_write;
   assign timer_sel   = accept && (req_block == BLK_TIMER);
   assign int_sel     = accept && (req_block == BLK_INT);
   assign scratch_sel = accept && (req_block == BLK_SCRATCH);

   always_comb begin
      case (req_block)
         BLK_TIMER:   read_mux = timer_rdata;
         BLK_INT:     read_mux = int_rdata;
         BLK_SCRATCH: read_mux = scratch_rdata;
         default:     read_mux = `OPEN_BUS_DATA;
      endcase
   end

   // Sampled in the accept cycle, held until the host takes it
   always_ff @(posedge clock) begin
      if (accept && !req_write) begin
         resp_rdata <= read_mux;
      end
   end

endmodule

//--- logic/io_scratch_regs.sv
`include "gbc_io_defs.svh"

module io_scratch_regs import gbc_io_pkg::*; (
   input  logic     clock,
   input  logic     rst,
   input  logic     scratch_sel,
   input  logic     wr_en,
   input  io_addr_t reg_addr,
   input  io_data_t wdata,
   output io_data_t scratch_rdata
);

   localparam int NUM_REGS = 6;

   // Storage table for RP, 0xFF6C and 0xFF72 to 0xFF75
   localparam io_addr_t REG_ADDR [NUM_REGS] = '{
      `RP_ADDR, `UNUSED_6C_ADDR, `UNUSED_72_ADDR,
      `UNUSED_73_ADDR, `UNUSED_74_ADDR, `UNUSED_75_ADDR
   };
   localparam io_data_t REG_RESET [NUM_REGS] = '{
      `RP_RESET, `UNUSED_6C_RESET, 8'h00, 8'h00, 8'h00, `UNUSED_75_RESET
   };
   localparam io_data_t REG_WMASK [NUM_REGS] = '{
      `RP_WMASK, `UNUSED_6C_WMASK, 8'hFF, 8'hFF, 8'hFF, `UNUSED_75_WMASK
   };

   io_data_t regs [NUM_REGS];

   // Bits outside the mask never leave their reset value
   always_ff @(posedge clock) begin
      for (int i = 0; i < NUM_REGS; i++) begin
         if (rst) begin
            regs[i] <= REG_RESET[i];
         end else if (scratch_sel && wr_en && (reg_addr == REG_ADDR[i])) begin
            regs[i] <= (regs[i] & ~REG_WMASK[i]) | (wdata & REG_WMASK[i]);
         end
      end
   end

   // 0xFF76 and 0xFF77 are read only and always zero
   always_comb begin
      scratch_rdata = `OPEN_BUS_DATA;
      if ((reg_addr == `UNUSED_76_ADDR) || (reg_addr == `UNUSED_77_ADDR)) begin
         scratch_rdata = 8'h00;
      end
      for (int i = 0; i < NUM_REGS; i++) begin
         if (reg_addr == REG_ADDR[i]) begin
            scratch_rdata = regs[i];
         end
      end
   end

endmodule

//--- logic/timer_control.sv
`include "gbc_io_defs.svh"

module timer_control import gbc_io_pkg::*; (
   input  logic       clock,
   input  logic       rst,
   input  logic       timer_sel,
   input  logic       wr_en,
   input  io_addr_t   reg_addr,
   input  io_data_t   wdata,
   output io_data_t   tma,
   output io_data_t   tac_rdata,
   output logic       timer_enable,
   output logic [1:0] tick_period_sel
);

   // Enable in bit 2, rate select in bits 1:0
   logic [2:0] tac;
   logic       write_tma;
   logic       write_tac;

   assign write_tma = timer_sel && wr_en && (reg_addr == `TMA_ADDR);
   assign write_tac = timer_sel && wr_en && (reg_addr == `TAC_ADDR);

   always_ff @(posedge clock) begin
      if (rst) begin
         tma <= '0;
         tac <= '0;
      end else begin
         if (write_tma) begin
            tma <= wdata;
         end
         if (write_tac) begin
            tac <= wdata[2:0];
         end
      end
   end

   // Upper five bits read back as ones
   assign tac_rdata       = `TAC_UNUSED_BITS | {5'b00000, tac};
   assign timer_enable    = tac[2];
   assign tick_period_sel = tac[1:0];

endmodule

//--- logic/timer_counter.sv
`include "gbc_io_defs.svh"

module timer_counter import gbc_io_pkg::*; (
   input  logic       clock,
   input  logic       rst,
   input  logic       timer_sel,
   input  logic       wr_en,
   input  io_addr_t   reg_addr,
   input  io_data_t   wdata,
   input  io_data_t   tma,
   input  io_data_t   tac_rdata,
   input  logic       timer_enable,
   input  logic [1:0] tick_period_sel,
   output io_data_t   timer_rdata,
   output logic       timer_irq_pulse
);

   // Low divider bits that must all be ones on the last cycle of a period
   localparam logic [15:0] PERIOD_MASK_0 = 16'(`TIMER_PERIOD_0 - 1);
   localparam logic [15:0] PERIOD_MASK_1 = 16'(`TIMER_PERIOD_1 - 1);
   localparam logic [15:0] PERIOD_MASK_2 = 16'(`TIMER_PERIOD_2 - 1);
   localparam logic [15:0] PERIOD_MASK_3 = 16'(`TIMER_PERIOD_3 - 1);

   logic [15:0] div_count;
   logic [15:0] period_mask;
   io_data_t    tima;
   logic        write_div;
   logic        write_tima;
   logic        tick;
   logic        overflow;

   assign write_div  = timer_sel && wr_en && (reg_addr == `DIV_ADDR);
   assign write_tima = timer_sel && wr_en && (reg_addr == `TIMA_ADDR);

   // ==================================================
   // Divider
   // ==================================================
   // Any write to DIV clears all 16 bits
   always_ff @(posedge clock) begin
      if (rst || write_div) begin
         div_count <= '0;
      end else begin
         div_count <= div_count + 16'd1;
      end
   end

   always_comb begin
      case (tick_period_sel)
         2'd0:    period_mask = PERIOD_MASK_0;
         2'd1:    period_mask = PERIOD_MASK_1;
         2'd2:    period_mask = PERIOD_MASK_2;
         default: period_mask = PERIOD_MASK_3;
      endcase
   end

   assign tick     = timer_enable && ((div_count & period_mask) == period_mask);
   assign overflow = tick && (tima == 8'hFF) && !write_tima;

   // ==================================================
   // TIMA
   // ==================================================
   // Host write takes priority over the increment
   always_ff @(posedge clock) begin
      if (rst) begin
         tima            <= '0;
         timer_irq_pulse <= 1'b0;
      end else begin
         timer_irq_pulse <= overflow;
         if (write_tima) begin
            tima <= wdata;
         end else if (overflow) begin
            tima <= tma;
         end else if (tick) begin
            tima <= tima + 8'd1;
         end
      end
   end

   // DIV shows the upper byte of the divider
   always_comb begin
      case (reg_addr)
         `DIV_ADDR:  timer_rdata = io_data_t'(div_count / `DIV_PERIOD);
         `TIMA_ADDR: timer_rdata = tima;
         `TMA_ADDR:  timer_rdata = tma;
         `TAC_ADDR:  timer_rdata = tac_rdata;
         default:    timer_rdata = `OPEN_BUS_DATA;
      endcase
   end

endmodule

//--- test/gbc_io_checker.sv
module gbc_io_checker import gbc_io_pkg::*; (
   input logic     clock,
   input logic     rst,
   input logic     req_ready,
   input logic     resp_valid,
   input logic     resp_ready,
   input io_data_t resp_rdata,
   input logic     irq,
   input int_vec_t if_reg,
   input io_data_t ie_reg
);
   timeunit 1ns;
   timeprecision 100ps;

   // ==================================================
   // Host handshake
   // ==================================================
   // Response stays put until the host takes it
   resp_hold: assert property (@(posedge clock) disable iff (rst)
      (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp_rdata)))
      else $error("response changed or dropped while resp_ready was low");

   no_accept_while_responding: assert property (@(posedge clock) disable iff (rst)
      resp_valid |-> !req_ready)
      else $error("req_ready high while a response is pending");

   // ==================================================
   // Interrupt output
   // ==================================================
   irq_needs_pending: assert property (@(posedge clock) disable iff (rst)
      ((if_reg & ie_reg[4:0]) == 5'b00000) |-> !irq)
      else $error("irq high with no enabled interrupt pending");

endmodule

bind gbc_io_top gbc_io_checker u_checker (
   .clock      (clock),
   .rst        (rst),
   .req_ready  (req_ready),
   .resp_valid (resp_valid),
   .resp_ready (resp_ready),
   .resp_rdata (resp_rdata),
   .irq        (irq),
   .if_reg     (u_int_ctrl.if_reg),
   .ie_reg     (u_int_ctrl.ie_reg)
);

//--- test/gbc_io_tb.sv
`include "gbc_io_defs.svh"

module gbc_io_tb import gbc_io_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int BUS_TIMEOUT = 50;
   localparam int IRQ_TIMEOUT = 400;

   localparam io_addr_t SCRATCH_ADDRS [8] = '{
      `RP_ADDR, `UNUSED_6C_ADDR, `UNUSED_72_ADDR, `UNUSED_73_ADDR,
      `UNUSED_74_ADDR, `UNUSED_75_ADDR, `UNUSED_76_ADDR, `UNUSED_77_ADDR
   };
   // Static registers only, plus one unmapped address
   localparam io_addr_t STALL_ADDRS [13] = '{
      `RP_ADDR, `UNUSED_6C_ADDR, `UNUSED_72_ADDR, `UNUSED_73_ADDR,
      `UNUSED_74_ADDR, `UNUSED_75_ADDR, `UNUSED_76_ADDR, `UNUSED_77_ADDR,
      `TMA_ADDR, `TAC_ADDR, `IF_ADDR, `IE_ADDR, 16'hFF10
   };

   logic       clock;
   logic       rst;
   logic       req_valid;
   logic       req_write;
   io_addr_t   req_addr;
   io_data_t   req_wdata;
   logic       req_ready;
   logic       resp_valid;
   logic       resp_ready;
   io_data_t   resp_rdata;
   logic       vblank_req;
   logic       lcdstat_req;
   logic       serial_req;
   logic       joypad_req;
   logic       int_ack;
   logic       irq;
   int_index_t irq_index;

   // Register model of the 0xFFxx page, by low address byte
   io_data_t model_page [256];
   io_addr_t addr_q [$];
   io_data_t exp_q [$];
   bit       chk_q [$];
   int       check_count;
   int       error_count;
   int       timeout_count;

   gbc_io_top DUT (.*);

   always #20 clock = ~clock;

   // ==================================================
   // Reference model
   // ==================================================
   function automatic io_data_t write_mask(input io_addr_t addr);
      case (addr)
         `TIMA_ADDR, `TMA_ADDR, `IE_ADDR,
         `UNUSED_72_ADDR, `UNUSED_73_ADDR, `UNUSED_74_ADDR: return 8'hFF;
         `TAC_ADDR:       return 8'h07;
         `IF_ADDR:        return 8'h1F;
         `RP_ADDR:        return `RP_WMASK;
         `UNUSED_6C_ADDR: return `UNUSED_6C_WMASK;
         `UNUSED_75_ADDR: return `UNUSED_75_WMASK;
         default:         return 8'h00;
      endcase
   endfunction

   function automatic io_data_t expected_read(input io_addr_t addr);
      case (addr)
         // DIV is only read straight after a clearing write
         `DIV_ADDR: return 8'h00;
         `TIMA_ADDR, `TMA_ADDR, `IE_ADDR, `RP_ADDR, `UNUSED_6C_ADDR,
         `UNUSED_72_ADDR, `UNUSED_73_ADDR, `UNUSED_74_ADDR, `UNUSED_75_ADDR:
            return model_page[addr[7:0]];
         `TAC_ADDR: return `TAC_UNUSED_BITS | model_page[8'h07];
         `IF_ADDR:  return `IF_UNUSED_BITS | model_page[8'h0F];
         `UNUSED_76_ADDR, `UNUSED_77_ADDR: return 8'h00;
         default:   return `OPEN_BUS_DATA;
      endcase
   endfunction

   // Lowest set bit wins
   function automatic int_index_t lowest_pending(input int_vec_t pend);
      for (int i = 0; i < 5; i++) begin
         if (pend[i]) begin
            return int_index_t'(i);
         end
      end
      return '0;
   endfunction

   task automatic model_reset();
      for (int i = 0; i < 256; i++) begin
         model_page[i] = 8'h00;
      end
      model_page[8'h56] = `RP_RESET;
      model_page[8'h6C] = `UNUSED_6C_RESET;
      model_page[8'h75] = `UNUSED_75_RESET;
   endtask

   task automatic model_write(input io_addr_t addr, input io_data_t data);
      io_data_t mask;
      mask = write_mask(addr);
      model_page[addr[7:0]] = (model_page[addr[7:0]] & ~mask) | (data & mask);
   endtask

   // ==================================================
   // Checks and reporting
   // ==================================================
   task automatic compare_data(input io_addr_t addr, input io_data_t actual,
                               input io_data_t expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("[ERROR] %0t: read of %h returned %h, expected %h",
                  $time, addr, actual, expected);
      end
   endtask

   task automatic compare_index(input int_index_t actual, input int_index_t expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("[ERROR] %0t: irq_index is %0d, expected %0d", $time, actual, expected);
      end
   endtask

   task automatic report_and_finish();
      $display("Checks: %0d  errors: %0d  timeouts: %0d",
               check_count, error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   endtask

   task automatic timed_out(input string what);
      timeout_count++;
      $display("Timeout at %0t: %s did not happen in time", $time, what);
      report_and_finish();
   endtask

   // Responses transfer at the next rising edge, sampled half a cycle early
   always @(negedge clock) begin : compare_responses
      io_addr_t addr;
      io_data_t expected;
      bit       checked;
      if (!rst && resp_valid && resp_ready) begin
         if (exp_q.size() == 0) begin
            error_count++;
            $display("Response at %0t arrived with no read outstanding", $time);
         end else begin
            addr     = addr_q.pop_front();
            expected = exp_q.pop_front();
            checked  = chk_q.pop_front();
            if (checked) begin
               compare_data(addr, resp_rdata, expected);
            end
         end
      end
   end

   // ==================================================
   // Bus tasks
   // ==================================================
   task automatic next_drive_slot();
      @(posedge clock);
      #2;
   endtask

   task automatic issue_request(input logic write, input io_addr_t addr,
                                input io_data_t data);
      int waited;
      waited    = 0;
      req_valid = 1'b1;
      req_write = write;
      req_addr  = addr;
      req_wdata = data;
      while (!req_ready) begin
         next_drive_slot();
         waited++;
         if (waited > BUS_TIMEOUT) begin
            timed_out("request acceptance");
         end
      end
      next_drive_slot();
      req_valid = 1'b0;
   endtask

   task automatic bus_write(input io_addr_t addr, input io_data_t data);
      issue_request(1'b1, addr, data);
      model_write(addr, data);
   endtask

   task automatic bus_read(input io_addr_t addr, input bit check, input int stall,
                           output io_data_t data);
      int waited;
      addr_q.push_back(addr);
      exp_q.push_back(expected_read(addr));
      chk_q.push_back(check);
      issue_request(1'b0, addr, 8'h00);
      waited = 0;
      while (!resp_valid) begin
         next_drive_slot();
         waited++;
         if (waited > BUS_TIMEOUT) begin
            timed_out("read response");
         end
      end
      data = resp_rdata;
      if (stall > 0) begin
         // Offer a write to 0xFF72 that must not be taken while held
         resp_ready = 1'b0;
         req_valid  = 1'b1;
         req_write  = 1'b1;
         req_addr   = `UNUSED_72_ADDR;
         req_wdata  = ~model_page[8'h72];
         repeat (stall) begin
            next_drive_slot();
            check_count++;
            if (req_ready) begin
               error_count++;
               $display("[ERROR] %0t: req_ready high while response held", $time);
            end
         end
         req_valid  = 1'b0;
         resp_ready = 1'b1;
      end
      next_drive_slot();
   endtask

   task automatic pulse_requests(input int_vec_t bits);
      vblank_req  = bits[0];
      lcdstat_req = bits[1];
      serial_req  = bits[3];
      joypad_req  = bits[4];
      next_drive_slot();
      vblank_req  = 1'b0;
      lcdstat_req = 1'b0;
      serial_req  = 1'b0;
      joypad_req  = 1'b0;
      model_page[8'h0F] = model_page[8'h0F] | {3'b000, bits & 5'h1B};
   endtask

   task automatic wait_for_irq();
      int waited;
      waited = 0;
      while (!irq) begin
         next_drive_slot();
         waited++;
         if (waited > IRQ_TIMEOUT) begin
            timed_out("interrupt request");
         end
      end
   endtask

   task automatic check_irq_low(input string when);
      check_count++;
      if (irq) begin
         error_count++;
         $display("[ERROR] %0t: irq still high %s", $time, when);
      end
   endtask

   // ==================================================
   // Scenarios
   // ==================================================
   task automatic scratch_test();
      io_addr_t addr;
      io_data_t data;
      foreach (SCRATCH_ADDRS[i]) begin
         bus_read(SCRATCH_ADDRS[i], 1'b1, 0, data);
      end
      repeat (40) begin
         addr = SCRATCH_ADDRS[$urandom_range(7, 0)];
         bus_write(addr, io_data_t'($urandom));
         bus_read(addr, 1'b1, 0, data);
      end
      foreach (SCRATCH_ADDRS[i]) begin
         bus_read(SCRATCH_ADDRS[i], 1'b1, 0, data);
      end
      // Below the register page nothing is mapped
      repeat (8) begin
         bus_read(io_addr_t'($urandom_range(16'hFEFF, 0)), 1'b1, 0, data);
      end
      bus_read(16'hFF00, 1'b1, 0, data);
      bus_read(16'hFF57, 1'b1, 0, data);
      bus_read(16'hFF78, 1'b1, 0, data);
      bus_read(16'hFFFE, 1'b1, 0, data);
   endtask

   task automatic timer_config_test();
      io_data_t data;
      repeat (4) begin
         bus_write(`TAC_ADDR, io_data_t'($urandom) & 8'hFB);
         bus_write(`TMA_ADDR, io_data_t'($urandom));
         bus_write(`TIMA_ADDR, io_data_t'($urandom));
         bus_read(`TIMA_ADDR, 1'b1, 0, data);
         bus_read(`TMA_ADDR, 1'b1, 0, data);
         bus_read(`TAC_ADDR, 1'b1, 0, data);
         // Let the divider run past one DIV step so the clear shows
         repeat (`DIV_PERIOD) begin
            next_drive_slot();
         end
         bus_write(`DIV_ADDR, io_data_t'($urandom));
         bus_read(`DIV_ADDR, 1'b1, 0, data);
      end
   endtask

   task automatic timer_overflow_test();
      io_data_t data;
      bus_write(`TMA_ADDR, 8'h80);
      bus_write(`TIMA_ADDR, 8'hFE);
      bus_write(`IE_ADDR, 8'h04);
      bus_write(`TAC_ADDR, 8'h05);
      wait_for_irq();
      model_page[8'h0F] = model_page[8'h0F] | 8'h04;
      compare_index(irq_index, lowest_pending(int_vec_t'(model_page[8'h0F] & model_page[8'hFF])));
      bus_write(`TAC_ADDR, 8'h00);
      bus_read(`TIMA_ADDR, 1'b0, 0, data);
      check_count++;
      if (data < 8'h80) begin
         error_count++;
         $display("[ERROR] %0t: TIMA is %h after reload, expected at least 80", $time, data);
      end
      bus_read(`IF_ADDR, 1'b1, 0, data);
      bus_write(`IF_ADDR, 8'h00);
      bus_write(`IE_ADDR, 8'h00);
   endtask

   task automatic priority_test();
      int_vec_t pend;
      int_index_t idx;
      bus_write(`IE_ADDR, 8'h1F);
      repeat (3) begin
         pulse_requests((int_vec_t'($urandom) & 5'h1B) | 5'h18);
         wait_for_irq();
         pend = int_vec_t'(model_page[8'h0F] & model_page[8'hFF]);
         while (pend != 5'b00000) begin
            idx = lowest_pending(pend);
            compare_index(irq_index, idx);
            int_ack = 1'b1;
            next_drive_slot();
            int_ack = 1'b0;
            model_page[8'h0F][idx] = 1'b0;
            pend = int_vec_t'(model_page[8'h0F] & model_page[8'hFF]);
         end
         check_irq_low("after every request was acknowledged");
      end
   endtask

   task automatic if_clear_test();
      io_data_t data;
      pulse_requests((int_vec_t'($urandom) & 5'h1B) | 5'h01);
      bus_read(`IF_ADDR, 1'b1, 0, data);
      bus_write(`IF_ADDR, 8'h00);
      bus_read(`IF_ADDR, 1'b1, 0, data);
      check_irq_low("after IF was cleared");
      bus_write(`IE_ADDR, 8'h00);
   endtask

   task automatic backpressure_test();
      io_addr_t addr;
      io_data_t data;
      repeat (24) begin
         addr = STALL_ADDRS[$urandom_range(12, 0)];
         if ($urandom_range(3, 0) == 0) begin
            bus_write(addr, io_data_t'($urandom));
         end
         bus_read(addr, 1'b1, $urandom_range(6, 1), data);
      end
      // Exposes any write slipped in during a stall
      bus_read(`UNUSED_72_ADDR, 1'b1, 0, data);
   endtask

   // ==================================================
   // Main sequence
   // ==================================================
   initial begin
      int unsigned seed_value;
      clock       = 1'b0;
      rst         = 1'b1;
      req_valid   = 1'b0;
      req_write   = 1'b0;
      req_addr    = '0;
      req_wdata   = '0;
      resp_ready  = 1'b1;
      vblank_req  = 1'b0;
      lcdstat_req = 1'b0;
      serial_req  = 1'b0;
      joypad_req  = 1'b0;
      int_ack     = 1'b0;
      check_count   = 0;
      error_count   = 0;
      timeout_count = 0;
      seed_value = $urandom(71);
      model_reset();

      repeat (2) @(posedge clock);
      #2;
      rst = 1'b0;
      next_drive_slot();
      check_count++;
      if (!req_ready || resp_valid || irq) begin
         error_count++;
         $display("[ERROR] %0t: outputs not idle after reset", $time);
      end

      scratch_test();
      timer_config_test();
      timer_overflow_test();
      priority_test();
      if_clear_test();
      backpressure_test();

      if (exp_q.size() != 0) begin
         error_count++;
         $display("%0d reads never received a response", exp_q.size());
      end
      report_and_finish();
   end

endmodule
